// ==== include/rspOrder_defines.svh ====
`ifndef RSP_ORDER_DEFINES_SVH
`define RSP_ORDER_DEFINES_SVH

// Slots per channel in the reorder buffer and in the write tag heap
// Kept at a power of two so that the slot pointers wrap on their own
`define RSP_ORDER_SLOTS 8

// Width of the client tag carried on every request and response
`define RSP_ORDER_TAG_BITS 8

// Width of one read data word
`define RSP_ORDER_DATA_BITS 32

// Width of a request address
`define RSP_ORDER_ADDR_BITS 16

// A buffer reports full once fewer than this many slots are free
// The reserve absorbs the request issued while almost-full is still registered low
`define RSP_ORDER_MIN_FREE 2

`endif

// ==== hw/rspOrderPkg.sv ====
`include "rspOrder_defines.svh"

package rspOrderPkg;

    // Client tag as seen on requests and on responses
    typedef logic [`RSP_ORDER_TAG_BITS-1:0] tagT;

    // Slot index that replaces the client tag toward memory
    typedef logic [$clog2(`RSP_ORDER_SLOTS)-1:0] slotIdxT;

    // Free slot count, one bit wider than an index so it can hold the full depth
    typedef logic [$clog2(`RSP_ORDER_SLOTS+1)-1:0] slotCntT;

    // Read data word and request address
    typedef logic [`RSP_ORDER_DATA_BITS-1:0] dataT;
    typedef logic [`RSP_ORDER_ADDR_BITS-1:0] addrT;

    // Request channel label, also used to index per-channel vectors
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } reqOpE;

    // Control FSM. ST_RESET lasts one cycle after reset release
    typedef enum logic {
        ST_RESET,
        ST_RUN
    } ctrlStateE;

endpackage

// ==== hw/slotAllocIf.sv ====
`timescale 1ns/1ns

// Slot allocation channel between the control module and one buffer
// The buffer always offers the slot its next allocation will take
// The control module takes it with a one-cycle pulse on alloc
interface slotAllocIf;
    import rspOrderPkg::*;

    // Pulse from control that consumes the offered slot
    logic    alloc;
    // Client tag to park in the slot until the response comes back
    tagT     allocTag;
    // Slot the next alloc pulse will take, valid while notFull is high
    slotIdxT allocIdx;
    // High while the buffer still has more than its reserve free
    logic    notFull;

    // Control side
    modport requester
    (
        output alloc,
        output allocTag,
        input  allocIdx,
        input  notFull
    );

    // Buffer side
    modport provider
    (
        input  alloc,
        input  allocTag,
        output allocIdx,
        output notFull
    );

endinterface

// ==== hw/rspOrderCtrl.sv ====
`timescale 1ns/1ns

module rspOrderCtrl
(
    input  logic                 clk,
    input  logic                 arstN,
    // Client requests
    input  logic                 clientRdValid,
    input  rspOrderPkg::addrT    clientRdAddr,
    input  rspOrderPkg::tagT     clientRdTag,
    input  logic                 clientWrValid,
    input  rspOrderPkg::addrT    clientWrAddr,
    input  rspOrderPkg::tagT     clientWrTag,
    output logic                 clientAlmFull,
    // Memory requests
    input  logic                 memAlmFull,
    output logic                 memRdValid,
    output rspOrderPkg::addrT    memRdAddr,
    output rspOrderPkg::slotIdxT memRdIdx,
    output logic                 memWrValid,
    output rspOrderPkg::addrT    memWrAddr,
    output rspOrderPkg::slotIdxT memWrIdx,
    // Slot allocation toward the read buffer and the write heap
    slotAllocIf.requester        rdAlloc,
    slotAllocIf.requester        wrAlloc
);
    import rspOrderPkg::*;

    ctrlStateE  stateQ;
    logic       almFullQ;
    logic [1:0] chanFull;
    logic [1:0] chanReq;
    logic       mergedAlmFull;

    // ========================================
    // Merged almost-full
    // ========================================

    // Either buffer filling or the memory side pushing back stalls both
    // channels together, so reads and writes stay in load/store order
    always_comb
    begin
        chanFull[OP_READ]  = !rdAlloc.notFull;
        chanFull[OP_WRITE] = !wrAlloc.notFull;
        mergedAlmFull      = memAlmFull || (|chanFull);
    end

    // Almost-full comes up high out of reset and holds through ST_RESET
    // The first edge after release loads the real merged value
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            stateQ   <= ST_RESET;
            almFullQ <= 1'b1;
        end
        else
        begin
            // ST_RESET lasts a single cycle and the shim then stays running
            stateQ   <= ST_RUN;
            almFullQ <= mergedAlmFull;
        end
    end

    assign clientAlmFull = almFullQ;

    // ========================================
    // Request tag rewrite
    // ========================================

    // A request takes the offered slot and goes out in the same cycle with
    // the slot index in place of the client tag
    always_comb
    begin
        chanReq[OP_READ]  = clientRdValid && (stateQ == ST_RUN);
        chanReq[OP_WRITE] = clientWrValid && (stateQ == ST_RUN);

        rdAlloc.alloc    = chanReq[OP_READ];
        rdAlloc.allocTag = clientRdTag;
        memRdValid       = chanReq[OP_READ];
        memRdAddr        = clientRdAddr;
        memRdIdx         = rdAlloc.allocIdx;

        wrAlloc.alloc    = chanReq[OP_WRITE];
        wrAlloc.allocTag = clientWrTag;
        memWrValid       = chanReq[OP_WRITE];
        memWrAddr        = clientWrAddr;
        memWrIdx         = wrAlloc.allocIdx;
    end

endmodule

// ==== hw/readReorderBuf.sv ====
`timescale 1ns/1ns
`include "rspOrder_defines.svh"

module readReorderBuf
(
    input  logic                 clk,
    input  logic                 arstN,
    // Allocation from the control module
    slotAllocIf.provider         alloc,
    // Out-of-order read responses from memory
    input  logic                 memRdRspValid,
    input  rspOrderPkg::slotIdxT memRdRspIdx,
    input  rspOrderPkg::dataT    memRdRspData,
    // In-order read responses toward the client
    output logic                 clientRdRspValid,
    output rspOrderPkg::dataT    clientRdRspData,
    output rspOrderPkg::tagT     clientRdRspTag
);
    import rspOrderPkg::*;

    // ========================================
    // Slot storage
    // ========================================

    // Tag and data per slot, written by allocation and by memory response
    tagT                       tagMem [`RSP_ORDER_SLOTS];
    dataT                      dataMem [`RSP_ORDER_SLOTS];

    // Set when the response for a slot has landed, cleared when it leaves
    logic [`RSP_ORDER_SLOTS-1:0] filledQ;

    // Head is the oldest outstanding read and tail is the next slot to hand out
    slotIdxT headQ;
    slotIdxT tailQ;
    slotCntT freeCntQ;

    logic    headRelease;

    // The oldest read leaves as soon as its data is in
    // Filled is a register, so data written at one edge leaves after it at the earliest
    assign headRelease = filledQ[headQ];

    assign clientRdRspValid = headRelease;
    assign clientRdRspData  = dataMem[headQ];
    assign clientRdRspTag   = tagMem[headQ];

    // Offer the tail slot while more than the reserve is free
    assign alloc.allocIdx = tailQ;
    assign alloc.notFull  = (freeCntQ >= slotCntT'(`RSP_ORDER_MIN_FREE));

    always_ff @(posedge clk)
    begin
        if (alloc.alloc)
        begin
            tagMem[tailQ] <= alloc.allocTag;
        end
        if (memRdRspValid)
        begin
            dataMem[memRdRspIdx] <= memRdRspData;
        end
    end

    // ========================================
    // Pointers and fill state
    // ========================================

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            headQ    <= '0;
            tailQ    <= '0;
            freeCntQ <= slotCntT'(`RSP_ORDER_SLOTS);
            filledQ  <= '0;
        end
        else
        begin
            // The released slot and the responding slot are never the same,
            // since every slot sees exactly one response
            if (headRelease)
            begin
                filledQ[headQ] <= 1'b0;
                headQ          <= headQ + slotIdxT'(1);
            end
            if (memRdRspValid)
            begin
                filledQ[memRdRspIdx] <= 1'b1;
            end
            if (alloc.alloc)
            begin
                tailQ <= tailQ + slotIdxT'(1);
            end
            // Free count goes down per allocation and up per release
            freeCntQ <= freeCntQ - slotCntT'(alloc.alloc) + slotCntT'(headRelease);
        end
    end

endmodule

// ==== hw/writeTagHeap.sv ====
`timescale 1ns/1ns
`include "rspOrder_defines.svh"

module writeTagHeap
(
    input  logic                 clk,
    input  logic                 arstN,
    // Allocation from the control module
    slotAllocIf.provider         alloc,
    // Write responses from memory, in any order
    input  logic                 memWrRspValid,
    input  rspOrderPkg::slotIdxT memWrRspIdx,
    // Write responses toward the client, one cycle later
    output logic                 clientWrRspValid,
    output rspOrderPkg::tagT     clientWrRspTag
);
    import rspOrderPkg::*;

    // Client tags parked by slot index
    tagT     tagMem [`RSP_ORDER_SLOTS];

    // Free list as a ring of slot indices with pop and push pointers
    slotIdxT freeListQ [`RSP_ORDER_SLOTS];
    slotIdxT popPtrQ;
    slotIdxT pushPtrQ;
    slotCntT freeCntQ;

    logic    rspValidQ;
    tagT     rspTagQ;

    assign alloc.allocIdx = freeListQ[popPtrQ];
    assign alloc.notFull  = (freeCntQ >= slotCntT'(`RSP_ORDER_MIN_FREE));

    // ========================================
    // Tag store and response lookup
    // ========================================

    always_ff @(posedge clk)
    begin
        if (alloc.alloc)
        begin
            tagMem[alloc.allocIdx] <= alloc.allocTag;
        end
        // Registered lookup, the tag is presented the cycle after the response
        if (memWrRspValid)
        begin
            rspTagQ <= tagMem[memWrRspIdx];
        end
    end

    assign clientWrRspValid = rspValidQ;
    assign clientWrRspTag   = rspTagQ;

    // ========================================
    // Free list
    // ========================================

    // The list starts holding every slot in order
    // A freed index is pushed at the same edge its tag is read out
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            for (int i = 0; i < `RSP_ORDER_SLOTS; i++)
            begin
                freeListQ[i] <= slotIdxT'(i);
            end
            popPtrQ   <= '0;
            pushPtrQ  <= '0;
            freeCntQ  <= slotCntT'(`RSP_ORDER_SLOTS);
            rspValidQ <= 1'b0;
        end
        else
        begin
            rspValidQ <= memWrRspValid;
            if (alloc.alloc)
            begin
                popPtrQ <= popPtrQ + slotIdxT'(1);
            end
            if (memWrRspValid)
            begin
                freeListQ[pushPtrQ] <= memWrRspIdx;
                pushPtrQ            <= pushPtrQ + slotIdxT'(1);
            end
            freeCntQ <= freeCntQ - slotCntT'(alloc.alloc) + slotCntT'(memWrRspValid);
        end
    end

endmodule

// ==== hw/rspOrderTop.sv ====
`timescale 1ns/1ns

module rspOrderTop
(
    input  logic                 clk,
    input  logic                 arstN,
    // Client requests
    input  logic                 clientRdValid,
    input  rspOrderPkg::addrT    clientRdAddr,
    input  rspOrderPkg::tagT     clientRdTag,
    input  logic                 clientWrValid,
    input  rspOrderPkg::addrT    clientWrAddr,
    input  rspOrderPkg::tagT     clientWrTag,
    output logic                 clientAlmFull,
    // Client responses
    output logic                 clientRdRspValid,
    output rspOrderPkg::dataT    clientRdRspData,
    output rspOrderPkg::tagT     clientRdRspTag,
    output logic                 clientWrRspValid,
    output rspOrderPkg::tagT     clientWrRspTag,
    // Memory requests
    output logic                 memRdValid,
    output rspOrderPkg::addrT    memRdAddr,
    output rspOrderPkg::slotIdxT memRdIdx,
    output logic                 memWrValid,
    output rspOrderPkg::addrT    memWrAddr,
    output rspOrderPkg::slotIdxT memWrIdx,
    input  logic                 memAlmFull,
    // Memory responses
    input  logic                 memRdRspValid,
    input  rspOrderPkg::slotIdxT memRdRspIdx,
    input  rspOrderPkg::dataT    memRdRspData,
    input  logic                 memWrRspValid,
    input  rspOrderPkg::slotIdxT memWrRspIdx
);

    // One allocation channel per request channel
    slotAllocIf rdAlloc ();
    slotAllocIf wrAlloc ();

    // Almost-full merge and tag rewrite on the request path
    rspOrderCtrl iCtrl
    (
        .clk, .arstN,
        .clientRdValid, .clientRdAddr, .clientRdTag,
        .clientWrValid, .clientWrAddr, .clientWrTag,
        .clientAlmFull, .memAlmFull,
        .memRdValid, .memRdAddr, .memRdIdx,
        .memWrValid, .memWrAddr, .memWrIdx,
        .rdAlloc (rdAlloc.requester),
        .wrAlloc (wrAlloc.requester)
    );

    // Reads come back to the client in issue order
    readReorderBuf iRdBuf
    (
        .clk, .arstN,
        .alloc (rdAlloc.provider),
        .memRdRspValid, .memRdRspIdx, .memRdRspData,
        .clientRdRspValid, .clientRdRspData, .clientRdRspTag
    );

    // Writes come back in memory order with their tags restored
    writeTagHeap iWrHeap
    (
        .clk, .arstN,
        .alloc (wrAlloc.provider),
        .memWrRspValid, .memWrRspIdx,
        .clientWrRspValid, .clientWrRspTag
    );

endmodule

// ==== dv/memModel.sv ====
`timescale 1ns/1ns
`include "rspOrder_defines.svh"

// Out-of-order memory behind the shim
// Outstanding requests are kept in lists and answered in random order
module memModel
(
    input  logic                 clk,
    input  logic                 arstN,
    // Requests from the DUT
    input  logic                 memRdValid,
    input  rspOrderPkg::addrT    memRdAddr,
    input  rspOrderPkg::slotIdxT memRdIdx,
    input  logic                 memWrValid,
    input  rspOrderPkg::slotIdxT memWrIdx,
    output logic                 memAlmFull,
    // Responses toward the DUT
    output logic                 memRdRspValid,
    output rspOrderPkg::slotIdxT memRdRspIdx,
    output rspOrderPkg::dataT    memRdRspData,
    output logic                 memWrRspValid,
    output rspOrderPkg::slotIdxT memWrRspIdx,
    // Test controls from the testbench
    input  logic                 holdRsp,
    input  logic                 forceAlmFull,
    input  logic                 randAlmFull
);
    import rspOrderPkg::*;

    slotIdxT rdIdxList [$];
    addrT    rdAddrList [$];
    slotIdxT wrIdxList [$];
    logic    arstS;
    logic    holdS;
    logic    forceS;
    logic    randS;
    int      pick;

    initial
    begin
        arstS         = 1'b0;
        holdS         = 1'b0;
        forceS        = 1'b0;
        randS         = 1'b0;
        memAlmFull    = 1'b0;
        memRdRspValid = 1'b0;
        memRdRspIdx   = '0;
        memRdRspData  = '0;
        memWrRspValid = 1'b0;
        memWrRspIdx   = '0;
    end

    // Requests and controls are sampled mid-cycle, where they have settled
    always @(negedge clk)
    begin
        arstS  = arstN;
        holdS  = holdRsp;
        forceS = forceAlmFull;
        randS  = randAlmFull;
        if (arstN && memRdValid)
        begin
            rdIdxList.push_back(memRdIdx);
            rdAddrList.push_back(memRdAddr);
        end
        if (arstN && memWrValid)
        begin
            wrIdxList.push_back(memWrIdx);
        end
    end

    // ========================================
    // Response driver
    // ========================================

    // Outputs change shortly after the rising edge, like the client stimulus
    always @(posedge clk)
    begin
        #2;
        memRdRspValid = 1'b0;
        memWrRspValid = 1'b0;
        memAlmFull    = arstS && (forceS || (randS && ($urandom_range(7) == 0)));
        // Each channel answers in about three cycles out of four, from any slot
        if (arstS && !holdS && (rdIdxList.size() > 0) && ($urandom_range(3) != 0))
        begin
            pick          = $urandom_range(rdIdxList.size() - 1);
            memRdRspValid = 1'b1;
            memRdRspIdx   = rdIdxList[pick];
            // Read data follows the testbench reference so the checker can predict it
            memRdRspData  = rspOrderTb.expectData(rdAddrList[pick]);
            rdIdxList.delete(pick);
            rdAddrList.delete(pick);
        end
        if (arstS && !holdS && (wrIdxList.size() > 0) && ($urandom_range(3) != 0))
        begin
            pick          = $urandom_range(wrIdxList.size() - 1);
            memWrRspValid = 1'b1;
            memWrRspIdx   = wrIdxList[pick];
            wrIdxList.delete(pick);
        end
    end

endmodule

// ==== dv/rspOrderAsserts.sv ====
`timescale 1ns/1ns

// Protocol rules of the control module, checked at every clock edge
module rspOrderAsserts
(
    input logic clk,
    input logic arstN,
    input logic rdAllocPulse,
    input logic rdNotFull,
    input logic wrAllocPulse,
    input logic wrNotFull,
    input logic memAlmFull,
    input logic memRdValid,
    input logic memWrValid,
    input logic clientAlmFull
);
    import rspOrderPkg::*;

    logic [1:0] allocPulse;
    logic [1:0] notFull;

    // Channel vectors labelled by request opcode
    assign allocPulse[OP_READ]  = rdAllocPulse;
    assign allocPulse[OP_WRITE] = wrAllocPulse;
    assign notFull[OP_READ]     = rdNotFull;
    assign notFull[OP_WRITE]    = wrNotFull;

    // A slot is only taken when the buffer offered one at the edge before
    allocHasRoom: assert property (@(posedge clk) disable iff (!arstN)
        (allocPulse & ~$past(notFull)) == 2'b00)
        else $error("slot allocated while the buffer reported full");

    // Memory back-pressure holds off requests from the next cycle on
    memRespectsAlmFull: assert property (@(posedge clk) disable iff (!arstN)
        (memRdValid || memWrValid) |-> !$past(memAlmFull))
        else $error("memory request issued after memAlmFull was high");

    // Flow control starts closed for the first cycle out of reset
    almFullAfterReset: assert property (@(posedge clk)
        $rose(arstN) |-> clientAlmFull)
        else $error("clientAlmFull low in the first cycle after reset");

endmodule

bind rspOrderCtrl rspOrderAsserts iAsserts
(
    .clk           (clk),
    .arstN         (arstN),
    .rdAllocPulse  (rdAlloc.alloc),
    .rdNotFull     (rdAlloc.notFull),
    .wrAllocPulse  (wrAlloc.alloc),
    .wrNotFull     (wrAlloc.notFull),
    .memAlmFull    (memAlmFull),
    .memRdValid    (memRdValid),
    .memWrValid    (memWrValid),
    .clientAlmFull (clientAlmFull)
);

// ==== dv/rspOrderTb.sv ====
`timescale 1ns/1ns
`include "rspOrder_defines.svh"

module rspOrderTb;
    import rspOrderPkg::*;

    // About 600 requests fit in far fewer cycles, the rest is margin
    localparam int MaxCycles = 4000;

    logic    clk;
    logic    arstN;
    logic    clientRdValid;
    addrT    clientRdAddr;
    tagT     clientRdTag;
    logic    clientWrValid;
    addrT    clientWrAddr;
    tagT     clientWrTag;
    logic    clientAlmFull;
    logic    clientRdRspValid;
    dataT    clientRdRspData;
    tagT     clientRdRspTag;
    logic    clientWrRspValid;
    tagT     clientWrRspTag;
    logic    memRdValid;
    addrT    memRdAddr;
    slotIdxT memRdIdx;
    logic    memWrValid;
    addrT    memWrAddr;
    slotIdxT memWrIdx;
    logic    memAlmFull;
    logic    memRdRspValid;
    slotIdxT memRdRspIdx;
    dataT    memRdRspData;
    logic    memWrRspValid;
    slotIdxT memWrRspIdx;
    logic    holdRsp;
    logic    forceAlmFull;
    logic    randAlmFull;

    // Scoreboard state, reads in issue order and writes as an unordered set
    addrT    rdAddrQ [$];
    tagT     rdTagQ [$];
    tagT     wrTags [$];
    tagT     wrTagByIdx [`RSP_ORDER_SLOTS];
    tagT     rdTagNext;
    tagT     wrTagNext;
    logic    pendWrValid;
    tagT     pendWrTag;
    addrT    expAddr;
    tagT     expTag;
    int      errCount;
    int      checkCount;
    int      rdIssued;
    int      wrIssued;
    int      cycleCount;
    int      burstCount;

    // Slots that memory has been asked about and not yet answered
    logic [`RSP_ORDER_SLOTS-1:0] rdIdxBusy;
    logic [`RSP_ORDER_SLOTS-1:0] wrIdxBusy;

    // Reference read data, address XORed with a constant and rotated by its low bits
    function automatic dataT expectData(input addrT addr);
        logic [31:0] mixed;
        logic [5:0]  rot;
        mixed = {addr, addr} ^ 32'h5a3c_96e1;
        rot   = {1'b0, addr[4:0]};
        return (mixed << rot) | (mixed >> (6'd32 - rot));
    endfunction

    always #10 clk = ~clk;

    rspOrderTop i_dut (.*);

    memModel iMem (.*);

    // ========================================
    // Checking helpers
    // ========================================

    task automatic compareField(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errCount++;
        end
    endtask

    task automatic flagError(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        errCount++;
    endtask

    // A write response must match one write that is still outstanding
    task automatic retireWrite(input tagT tag);
        int found;
        found = -1;
        foreach (wrTags[i])
        begin
            if (found < 0 && wrTags[i] == tag)
            begin
                found = i;
            end
        end
        assert (found >= 0)
        else flagError($sformatf("write response tag %h matches no outstanding write", tag));
        if (found >= 0)
        begin
            wrTags.delete(found);
        end
    endtask

    task automatic printCounts();
        $display("Summary: %0d checks, %0d errors, %0d reads and %0d writes issued",
                 checkCount, errCount, rdIssued, wrIssued);
    endtask

    // Compare process, sampling mid-cycle where all outputs are settled
    always @(negedge clk)
    begin
        if (arstN)
        begin
            if (memRdValid)
            begin
                compareField("memRdAddr", memRdAddr, clientRdAddr);
                // A slot carries one read at a time
                assert (!rdIdxBusy[memRdIdx])
                else flagError($sformatf("memRdIdx %0d reused while still outstanding",
                                         memRdIdx));
                rdIdxBusy[memRdIdx] = 1'b1;
            end
            if (memWrValid)
            begin
                compareField("memWrAddr", memWrAddr, clientWrAddr);
                assert (!wrIdxBusy[memWrIdx])
                else flagError($sformatf("memWrIdx %0d reused while still outstanding",
                                         memWrIdx));
                wrIdxBusy[memWrIdx]  = 1'b1;
                wrTagByIdx[memWrIdx] = clientWrTag;
            end
            if (clientRdRspValid)
            begin
                assert (rdAddrQ.size() > 0)
                else flagError("read response arrived with no read outstanding");
                if (rdAddrQ.size() > 0)
                begin
                    expAddr = rdAddrQ.pop_front();
                    expTag  = rdTagQ.pop_front();
                    compareField("clientRdRspData", clientRdRspData, expectData(expAddr));
                    compareField("clientRdRspTag", clientRdRspTag, expTag);
                end
            end
            // The write response is due exactly one cycle after the memory one
            compareField("clientWrRspValid", clientWrRspValid, pendWrValid);
            if (pendWrValid && clientWrRspValid)
            begin
                compareField("clientWrRspTag", clientWrRspTag, pendWrTag);
                retireWrite(clientWrRspTag);
            end
            if (memRdRspValid)
            begin
                rdIdxBusy[memRdRspIdx] = 1'b0;
            end
            if (memWrRspValid)
            begin
                wrIdxBusy[memWrRspIdx] = 1'b0;
            end
            pendWrValid = memWrRspValid;
            pendWrTag   = wrTagByIdx[memWrRspIdx];
        end
    end

    always @(posedge clk)
    begin
        cycleCount++;
        if (cycleCount >= MaxCycles)
        begin
            $display("Timeout after %0d cycles, responses still missing for %0d reads, %0d writes",
                     cycleCount, rdAddrQ.size(), wrTags.size());
            printCounts();
            $display("Test failed");
            $finish;
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // One request cycle, held back while the shim reports almost-full
    task automatic issueRequests(input logic doRd, input addrT rdAddr,
                                 input logic doWr, input addrT wrAddr);
        while (clientAlmFull)
        begin
            nextCycle();
        end
        clientRdValid = doRd;
        clientRdAddr  = rdAddr;
        clientRdTag   = rdTagNext;
        clientWrValid = doWr;
        clientWrAddr  = wrAddr;
        clientWrTag   = wrTagNext;
        if (doRd)
        begin
            rdAddrQ.push_back(rdAddr);
            rdTagQ.push_back(rdTagNext);
            rdTagNext = rdTagNext + 1'b1;
            rdIssued++;
        end
        if (doWr)
        begin
            wrTags.push_back(wrTagNext);
            wrTagNext = wrTagNext + 1'b1;
            wrIssued++;
        end
        nextCycle();
        clientRdValid = 1'b0;
        clientWrValid = 1'b0;
    endtask

    task automatic drainAll();
        while (rdAddrQ.size() != 0 || wrTags.size() != 0 || pendWrValid)
        begin
            nextCycle();
        end
        nextCycle();
    endtask

    initial
    begin
        clk           = 1'b0;
        arstN         = 1'b0;
        clientRdValid = 1'b0;
        clientRdAddr  = '0;
        clientRdTag   = '0;
        clientWrValid = 1'b0;
        clientWrAddr  = '0;
        clientWrTag   = '0;
        holdRsp       = 1'b0;
        forceAlmFull  = 1'b0;
        randAlmFull   = 1'b0;
        rdTagNext     = 8'h10;
        wrTagNext     = 8'h80;
        pendWrValid   = 1'b0;
        pendWrTag     = '0;
        rdIdxBusy     = '0;
        wrIdxBusy     = '0;
        errCount      = 0;
        checkCount    = 0;
        rdIssued      = 0;
        wrIssued      = 0;
        cycleCount    = 0;
        void'($urandom(32'hf508e1b5));

        // Reset for three cycles, then almost-full stays up for exactly one
        repeat (3) @(posedge clk);
        #2;
        arstN = 1'b1;
        @(negedge clk);
        compareField("clientAlmFull", clientAlmFull, 1'b1);
        compareField("valids after reset",
                     {clientRdRspValid, clientWrRspValid, memRdValid, memWrValid}, 4'b0000);
        @(negedge clk);
        compareField("clientAlmFull", clientAlmFull, 1'b0);
        nextCycle();

        // Single reads, each drained before the next
        repeat (6)
        begin
            issueRequests(1'b1, addrT'($urandom), 1'b0, '0);
            drainAll();
        end

        // Read bursts answered out of order by the model
        repeat (4)
        begin
            repeat (12) issueRequests(1'b1, addrT'($urandom), 1'b0, '0);
            drainAll();
        end

        // Write bursts with tags restored on the way back
        repeat (12) issueRequests(1'b0, '0, 1'b1, addrT'($urandom));
        drainAll();

        // Responses held back, so the read buffer fills to its reserve
        holdRsp    = 1'b1;
        burstCount = 0;
        while (!clientAlmFull && burstCount < 12)
        begin
            issueRequests(1'b1, addrT'($urandom), 1'b0, '0);
            burstCount++;
        end
        compareField("reads accepted before clientAlmFull", burstCount, `RSP_ORDER_SLOTS);
        repeat (4)
        begin
            nextCycle();
            compareField("clientAlmFull", clientAlmFull, 1'b1);
        end
        holdRsp = 1'b0;
        drainAll();

        // Memory back-pressure alone also closes the client side
        forceAlmFull = 1'b1;
        repeat (3) nextCycle();
        compareField("clientAlmFull", clientAlmFull, 1'b1);
        forceAlmFull = 1'b0;
        repeat (4) issueRequests(1'b1, addrT'($urandom), 1'b1, addrT'($urandom));
        drainAll();

        // Long mixed run with random memory back-pressure
        randAlmFull = 1'b1;
        repeat (400)
        begin
            issueRequests(1'($urandom), addrT'($urandom), 1'($urandom), addrT'($urandom));
        end
        randAlmFull = 1'b0;
        drainAll();

        printCounts();
        if (errCount == 0)
        begin
            $display("Test passed");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
hw/rspOrderPkg.sv
hw/slotAllocIf.sv
hw/rspOrderCtrl.sv
hw/readReorderBuf.sv
hw/writeTagHeap.sv
hw/rspOrderTop.sv
dv/memModel.sv
dv/rspOrderAsserts.sv
dv/rspOrderTb.sv

// ==== Bender.yml ====
package:
  name: rsp_order

sources:
  - include_dirs:
      - include
    files:
      - hw/rspOrderPkg.sv
      - hw/slotAllocIf.sv
      - hw/rspOrderCtrl.sv
      - hw/readReorderBuf.sv
      - hw/writeTagHeap.sv
      - hw/rspOrderTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/memModel.sv
      - dv/rspOrderAsserts.sv
      - dv/rspOrderTb.sv
